//--- Makefile
VERILATOR ?= verilator
TOP       ?= rv_core_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= files.f
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard common/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- common/rv_pkg.sv
`include "rv_settings.svh"

package rv_pkg;

  // Machine word, used for PC, data and immediates
  typedef logic [`RV_XLEN-1:0] rv_word_t;

  // Register index, x0 to x31
  typedef logic [4:0] rv_reg_t;

  // ----------------------------------------
  // Internal opcodes
  // ----------------------------------------

  // Decoded operation carried down the pipeline
  // ADDI maps onto OP_ADD with the immediate as second operand
  typedef enum logic [3:0] {
    OP_NOP    = 4'd0,
    OP_ADD    = 4'd1,
    OP_SUB    = 4'd2,
    OP_AND    = 4'd3,
    OP_OR     = 4'd4,
    OP_XOR    = 4'd5,
    OP_SLT    = 4'd6,
    OP_LUI    = 4'd7,
    OP_LW     = 4'd8,
    OP_SW     = 4'd9,
    OP_BEQ    = 4'd10,
    OP_BNE    = 4'd11,
    OP_JAL    = 4'd12,
    OP_EBREAK = 4'd13
  } rv_op_e;

endpackage

//--- common/rv_settings.svh
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ----------------------------------------
// Core widths
// ----------------------------------------

// Data and address width
`define RV_XLEN 32

// PC loaded while arst_n is low
`define RV_RESET_PC 32'h0000_0000

`endif

//--- common/rv_stage_if.sv
`timescale 1ns/1ps

// ID to EX bundle
interface id_ex_if import rv_pkg::*; (
  input logic clk
);
  logic     valid;
  rv_op_e   op;
  rv_word_t pc;
  rv_word_t rs1_data;
  rv_word_t rs2_data;
  rv_word_t imm;
  rv_reg_t  rd;

  modport producer (input clk, output valid, op, pc, rs1_data, rs2_data, imm, rd);
  modport consumer (input clk, input valid, op, pc, rs1_data, rs2_data, imm, rd);
endinterface

// EX to MW bundle
interface ex_mw_if import rv_pkg::*; (
  input logic clk
);
  logic     valid;
  rv_op_e   op;
  // ALU result, link value, or memory address
  rv_word_t result;
  rv_word_t store_data;
  rv_reg_t  rd;

  modport producer (input clk, output valid, op, result, store_data, rd);
  modport consumer (input clk, input valid, op, result, store_data, rd);
endinterface

//--- core/rv_decode.sv
`timescale 1ns/1ps

module rv_decode import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  rv_word_t instr,
  input  rv_word_t pc_id,
  input  logic     valid_id,
  input  logic     flush,
  input  logic     wb_en,
  input  rv_reg_t  wb_rd,
  input  rv_word_t wb_data,
  id_ex_if.producer id_ex
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  rv_reg_t    rd;
  rv_reg_t    rs1;
  rv_reg_t    rs2;
  rv_word_t   imm_i;
  rv_word_t   imm_s;
  rv_word_t   imm_b;
  rv_word_t   imm_u;
  rv_word_t   imm_j;
  rv_word_t   imm;
  rv_op_e     op;
  logic       use_imm;
  rv_word_t   rs1_data;
  rv_word_t   rs2_data;
  rv_word_t   regs [32];

  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];
  assign funct7 = instr[31:25];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // Unsupported encodings fall through as OP_NOP
  always_comb begin
    op      = OP_NOP;
    imm     = imm_i;
    use_imm = 1'b0;
    case (opcode)
      7'b0110011: begin
        case ({funct7, funct3})
          {7'h00, 3'b000}: op = OP_ADD;
          {7'h20, 3'b000}: op = OP_SUB;
          {7'h00, 3'b111}: op = OP_AND;
          {7'h00, 3'b110}: op = OP_OR;
          {7'h00, 3'b100}: op = OP_XOR;
          {7'h00, 3'b010}: op = OP_SLT;
          default: op = OP_NOP;
        endcase
      end
      7'b0010011: begin
        if (funct3 == 3'b000) begin
          op      = OP_ADD;
          use_imm = 1'b1;
        end
      end
      7'b0110111: begin
        op  = OP_LUI;
        imm = imm_u;
      end
      7'b0000011: if (funct3 == 3'b010) op = OP_LW;
      7'b0100011: begin
        imm = imm_s;
        if (funct3 == 3'b010) op = OP_SW;
      end
      7'b1100011: begin
        imm = imm_b;
        if (funct3 == 3'b000) op = OP_BEQ;
        if (funct3 == 3'b001) op = OP_BNE;
      end
      7'b1101111: begin
        op  = OP_JAL;
        imm = imm_j;
      end
      7'b1110011: if (instr == 32'h0010_0073) op = OP_EBREAK;
      default: op = OP_NOP;
    endcase
  end

  // ----------------------------------------
  // Register file
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // x0 reads as zero, same-cycle write-back passes through
  assign rs1_data = (rs1 == '0) ? '0 :
                    (wb_en && wb_rd == rs1) ? wb_data : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 :
                    (wb_en && wb_rd == rs2) ? wb_data : regs[rs2];

  // ----------------------------------------
  // ID/EX register
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid <= valid_id && !flush;
    end
  end

  always_ff @(posedge clk) begin
    id_ex.op       <= op;
    id_ex.pc       <= pc_id;
    id_ex.rs1_data <= rs1_data;
    // ADDI takes its immediate as the second ALU operand
    id_ex.rs2_data <= use_imm ? imm : rs2_data;
    id_ex.imm      <= imm;
    id_ex.rd       <= rd;
  end

endmodule

//--- core/rv_execute.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_execute import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  id_ex_if.consumer id_ex,
  ex_mw_if.producer ex_mw,
  output logic     redirect,
  output rv_word_t target
);

  rv_word_t result;
  rv_word_t pc_plus4;
  logic     equal;
  logic     taken;

  assign pc_plus4 = id_ex.pc + `RV_XLEN'(4);

  // ----------------------------------------
  // ALU
  // ----------------------------------------
  always_comb begin
    case (id_ex.op)
      OP_ADD:       result = id_ex.rs1_data + id_ex.rs2_data;
      OP_SUB:       result = id_ex.rs1_data - id_ex.rs2_data;
      OP_AND:       result = id_ex.rs1_data & id_ex.rs2_data;
      OP_OR:        result = id_ex.rs1_data | id_ex.rs2_data;
      OP_XOR:       result = id_ex.rs1_data ^ id_ex.rs2_data;
      OP_SLT:       result = rv_word_t'($signed(id_ex.rs1_data) < $signed(id_ex.rs2_data));
      OP_LUI:       result = id_ex.imm;
      OP_JAL:       result = pc_plus4;
      // Address for loads and stores
      OP_LW, OP_SW: result = id_ex.rs1_data + id_ex.imm;
      default:      result = '0;
    endcase
  end

  // Branch compare and target
  assign equal  = (id_ex.rs1_data == id_ex.rs2_data);
  assign taken  = (id_ex.op == OP_BEQ && equal) ||
                  (id_ex.op == OP_BNE && !equal) ||
                  (id_ex.op == OP_JAL);
  assign target = id_ex.pc + id_ex.imm;

  // Flushed slots never redirect, so this is one cycle wide
  assign redirect = id_ex.valid && taken;

  // ----------------------------------------
  // EX/MW register
  // ----------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mw.valid <= 1'b0;
    end else begin
      ex_mw.valid <= id_ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    ex_mw.op         <= id_ex.op;
    ex_mw.result     <= result;
    ex_mw.store_data <= id_ex.rs2_data;
    ex_mw.rd         <= id_ex.rd;
  end

endmodule

//--- core/rv_fetch.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_fetch import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     redirect,
  input  rv_word_t target,
  input  rv_word_t imem_rdata,
  output rv_word_t imem_addr,
  output rv_word_t instr,
  output rv_word_t pc_id,
  output logic     valid_id
);

  rv_word_t pc;
  rv_word_t pc_next;

  // Taken branch or JAL in EX overrides sequential fetch
  assign pc_next   = redirect ? target : pc + `RV_XLEN'(4);
  assign imem_addr = pc;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc       <= `RV_RESET_PC;
      valid_id <= 1'b0;
    end else begin
      pc       <= pc_next;
      // The word fetched alongside a redirect is on the wrong path
      valid_id <= !redirect;
    end
  end

  // ----------------------------------------
  // IF/ID payload
  // ----------------------------------------
  always_ff @(posedge clk) begin
    instr <= imem_rdata;
    pc_id <= pc;
  end

endmodule

//--- core/rv_memwb.sv
`timescale 1ns/1ps

module rv_memwb import rv_pkg::*; (
  ex_mw_if.consumer ex_mw,
  input  rv_word_t  dmem_rdata,
  output rv_word_t  dmem_addr,
  output rv_word_t  dmem_wdata,
  output logic      dmem_we,
  output logic      wb_en,
  output rv_reg_t   wb_rd,
  output rv_word_t  wb_data,
  output logic      ebreak
);

  logic writes_rd;

  // Data memory port, word access only
  assign dmem_addr  = ex_mw.result;
  assign dmem_wdata = ex_mw.store_data;
  assign dmem_we    = ex_mw.valid && ex_mw.op == OP_SW;

  // Ops that produce a register result
  always_comb begin
    case (ex_mw.op)
      OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: writes_rd = 1'b1;
      OP_LUI, OP_LW, OP_JAL:                         writes_rd = 1'b1;
      default:                                       writes_rd = 1'b0;
    endcase
  end

  assign wb_en   = ex_mw.valid && writes_rd;
  assign wb_rd   = ex_mw.rd;
  assign wb_data = (ex_mw.op == OP_LW) ? dmem_rdata : ex_mw.result;

  assign ebreak = ex_mw.valid && ex_mw.op == OP_EBREAK;

endmodule

//--- files.f
+incdir+common
common/rv_pkg.sv
common/rv_stage_if.sv
core/rv_fetch.sv
core/rv_decode.sv
core/rv_execute.sv
core/rv_memwb.sv
src/rv_core.sv
testbench/rv_core_props.sv
testbench/rv_core_tb.sv

//--- src/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  output rv_word_t imem_addr,
  input  rv_word_t imem_rdata,
  output rv_word_t dmem_addr,
  output rv_word_t dmem_wdata,
  output logic     dmem_we,
  input  rv_word_t dmem_rdata,
  output logic     ebreak
);

  rv_word_t instr;
  rv_word_t pc_id;
  logic     valid_id;
  logic     redirect;
  rv_word_t target;
  logic     wb_en;
  rv_reg_t  wb_rd;
  rv_word_t wb_data;

  id_ex_if id_ex (.clk(clk));
  ex_mw_if ex_mw (.clk(clk));

  // ----------------------------------------
  // Pipeline stages
  // ----------------------------------------
  rv_fetch fetch (
    .clk       (clk),
    .arst_n    (arst_n),
    .redirect  (redirect),
    .target    (target),
    .imem_rdata(imem_rdata),
    .imem_addr (imem_addr),
    .instr     (instr),
    .pc_id     (pc_id),
    .valid_id  (valid_id)
  );

  // Redirect doubles as the ID flush
  rv_decode decode (
    .clk     (clk),
    .arst_n  (arst_n),
    .instr   (instr),
    .pc_id   (pc_id),
    .valid_id(valid_id),
    .flush   (redirect),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_data (wb_data),
    .id_ex   (id_ex.producer)
  );

  rv_execute execute (
    .clk     (clk),
    .arst_n  (arst_n),
    .id_ex   (id_ex.consumer),
    .ex_mw   (ex_mw.producer),
    .redirect(redirect),
    .target  (target)
  );

  rv_memwb memwb (
    .ex_mw     (ex_mw.consumer),
    .dmem_rdata(dmem_rdata),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .wb_en     (wb_en),
    .wb_rd     (wb_rd),
    .wb_data   (wb_data),
    .ebreak    (ebreak)
  );

endmodule

//--- testbench/rv_core_props.sv
`timescale 1ns/1ps

module rv_core_props import rv_pkg::*; (
  input logic     clk,
  input logic     arst_n,
  input rv_word_t imem_addr,
  input rv_word_t dmem_addr,
  input logic     dmem_we,
  input logic     ebreak
);

  // Strobes stay low in reset
  reset_quiet: assert property (@(posedge clk) !arst_n |-> (!dmem_we && !ebreak))
    else $error("dmem_we or ebreak high while arst_n is low");

  fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n) imem_addr[1:0] == 2'b00)
    else $error("imem_addr is not word aligned");

  // Stores only ever target whole words
  store_aligned: assert property (@(posedge clk) disable iff (!arst_n)
                                  dmem_we |-> dmem_addr[1:0] == 2'b00)
    else $error("store address is not word aligned");

endmodule

bind rv_core rv_core_props props_i (
  .clk      (clk),
  .arst_n   (arst_n),
  .imem_addr(imem_addr),
  .dmem_addr(dmem_addr),
  .dmem_we  (dmem_we),
  .ebreak   (ebreak)
);

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ps

`include "rv_settings.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam rv_word_t NOP_W          = 32'h0000_0013;
  localparam rv_word_t EBREAK_W       = 32'h0010_0073;
  localparam int       TIMEOUT_CYCLES = 500;

  logic     clk = 1'b0;
  logic     arst_n;
  rv_word_t imem_addr;
  rv_word_t imem_rdata;
  rv_word_t dmem_addr;
  rv_word_t dmem_wdata;
  logic     dmem_we;
  rv_word_t dmem_rdata;
  logic     ebreak;

  rv_word_t imem [1024];
  rv_word_t dmem [1024];
  rv_word_t store_addrs [$];
  int       n_instr;
  integer   seed;

  always #4 clk = ~clk;

  rv_core rv_core_i (
    .clk       (clk),
    .arst_n    (arst_n),
    .imem_addr (imem_addr),
    .imem_rdata(imem_rdata),
    .dmem_addr (dmem_addr),
    .dmem_wdata(dmem_wdata),
    .dmem_we   (dmem_we),
    .dmem_rdata(dmem_rdata),
    .ebreak    (ebreak)
  );

  // ----------------------------------------
  // Memory models
  // ----------------------------------------
  assign imem_rdata = imem[imem_addr[11:2]];
  assign dmem_rdata = dmem[dmem_addr[11:2]];

  always @(posedge clk) begin
    if (dmem_we) begin
      dmem[dmem_addr[11:2]] <= dmem_wdata;
      store_addrs.push_back(dmem_addr);
    end
  end

  // Untouched words keep a value unique to their index
  function automatic rv_word_t fill_word(input logic [9:0] idx);
    return {6'h2b, idx, 6'h15, idx};
  endfunction

  function automatic rv_word_t mem_at(input rv_word_t addr);
    return dmem[addr[11:2]];
  endfunction

  // ----------------------------------------
  // Instruction encoders
  // ----------------------------------------
  function automatic rv_word_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                      input rv_reg_t rd, input rv_reg_t rs1, input rv_reg_t rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic rv_word_t addi(input rv_reg_t rd, input rv_reg_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
  endfunction

  function automatic rv_word_t lui(input rv_reg_t rd, input logic [19:0] imm);
    return {imm, rd, 7'b0110111};
  endfunction

  function automatic rv_word_t lw(input rv_reg_t rd, input rv_reg_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b010, rd, 7'b0000011};
  endfunction

  function automatic rv_word_t sw(input rv_reg_t rs2, input rv_reg_t rs1, input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
  endfunction

  function automatic rv_word_t branch(input logic [2:0] f3, input rv_reg_t rs1,
                                      input rv_reg_t rs2, input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic rv_word_t jal(input rv_reg_t rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // ----------------------------------------
  // Program loading and run control
  // ----------------------------------------
  task automatic emit(input rv_word_t w);
    imem[n_instr[9:0]] <= w;
    n_instr++;
  endtask

  // LUI plus ADDI, spaced so the next instruction may read rd
  task automatic load_const(input rv_reg_t rd, input rv_word_t v);
    rv_word_t hi;
    hi = (v + 32'h800) >> 12;
    emit(lui(rd, hi[19:0]));
    emit(NOP_W);
    emit(addi(rd, rd, v[11:0]));
    emit(NOP_W);
  endtask

  task automatic start_program();
    @(posedge clk);
    arst_n <= 1'b0;
    for (int i = 0; i < 1024; i++) begin
      // All-zero word decodes as a no-op
      imem[i[9:0]] <= '0;
      dmem[i[9:0]] <= fill_word(i[9:0]);
    end
    store_addrs.delete();
    n_instr = 0;
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic run_program();
    int cycles;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    cycles = 0;
    while (ebreak !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
        abort_run("Timeout: the core gave no ebreak pulse within 500 cycles");
      end
    end
  endtask

  task automatic check_word(input rv_word_t actual, input rv_word_t expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("ERR @%0t: %s is %h, expected %h", $time, what, actual, expected));
    end
  endtask

  task automatic check_addr(input rv_word_t actual, input rv_word_t expected, input string what);
    if (actual !== expected) begin
      abort_run($sformatf("ERR @%0t: address %s is %h, expected %h",
                          $time, what, actual, expected));
    end
  endtask

  // ----------------------------------------
  // Directed tests
  // ----------------------------------------
  task automatic alu_test();
    rv_word_t a;
    rv_word_t b;
    rv_word_t exp [7];
    a   = 32'h1234_5678;
    b   = 32'h8765_4321;
    exp = '{a + b, a - b, a & b, a | b, a ^ b,
            {31'd0, $signed(a) < $signed(b)}, {31'd0, $signed(b) < $signed(a)}};
    start_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b111, 5'd5, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b110, 5'd6, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b100, 5'd7, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b010, 5'd8, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b010, 5'd9, 5'd2, 5'd1));
    for (int k = 0; k < 7; k++) begin
      emit(sw(5'd3 + k[4:0], 5'd0, 12'h400 + {k[9:0], 2'b00}));
    end
    emit(EBREAK_W);
    run_program();
    for (int k = 0; k < 7; k++) begin
      check_word(mem_at(32'h400 + k * 4), exp[k], $sformatf("ALU result %0d", k));
    end
  endtask

  task automatic random_test();
    rv_word_t a;
    rv_word_t b;
    a = $random(seed);
    b = $random(seed);
    start_program();
    load_const(5'd1, a);
    load_const(5'd2, b);
    emit(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
    emit(r_type(7'h20, 3'b000, 5'd4, 5'd1, 5'd2));
    emit(r_type(7'h00, 3'b100, 5'd5, 5'd1, 5'd2));
    emit(sw(5'd3, 5'd0, 12'h400));
    emit(sw(5'd4, 5'd0, 12'h404));
    emit(sw(5'd5, 5'd0, 12'h408));
    emit(EBREAK_W);
    run_program();
    check_word(mem_at(32'h400), a + b, "random ADD");
    check_word(mem_at(32'h404), a - b, "random SUB");
    check_word(mem_at(32'h408), a ^ b, "random XOR");
  endtask

  task automatic round_trip_test();
    rv_word_t data;
    data = 32'h5a3c_96e1;
    start_program();
    load_const(5'd5, 32'h0000_0300);
    load_const(5'd6, data);
    emit(sw(5'd6, 5'd5, 12'h008));
    emit(lw(5'd7, 5'd5, 12'h008));
    emit(NOP_W);
    emit(sw(5'd7, 5'd0, 12'h500));
    emit(EBREAK_W);
    run_program();
    check_word(rv_word_t'(store_addrs.size()), 32'd2, "store count");
    check_addr(store_addrs[0], 32'h300 + 32'h8, "of first SW");
    check_addr(store_addrs[1], 32'h500, "of second SW");
    check_word(mem_at(32'h308), data, "stored word");
    check_word(mem_at(32'h500), data, "reloaded word");
  endtask

  task automatic branch_test();
    start_program();
    load_const(5'd1, 32'd5);
    load_const(5'd2, 32'd5);
    // Taken BEQ jumps over both stores
    emit(branch(3'b000, 5'd1, 5'd2, 13'd12));
    emit(sw(5'd1, 5'd0, 12'h600));
    emit(sw(5'd1, 5'd0, 12'h604));
    emit(branch(3'b001, 5'd1, 5'd2, 13'd8));
    emit(sw(5'd2, 5'd0, 12'h608));
    emit(EBREAK_W);
    run_program();
    check_word(mem_at(32'h600), fill_word(10'h180), "word skipped by BEQ");
    check_word(mem_at(32'h604), fill_word(10'h181), "second word skipped by BEQ");
    check_word(mem_at(32'h608), 32'd5, "store after BNE");
    check_word(rv_word_t'(store_addrs.size()), 32'd1, "store count");
  endtask

  task automatic jal_test();
    rv_word_t jal_pc;
    start_program();
    emit(NOP_W);
    jal_pc = `RV_RESET_PC + n_instr * 4;
    emit(jal(5'd1, 21'd12));
    emit(sw(5'd0, 5'd0, 12'h700));
    emit(sw(5'd0, 5'd0, 12'h704));
    emit(sw(5'd1, 5'd0, 12'h708));
    emit(EBREAK_W);
    run_program();
    check_addr(mem_at(32'h708), jal_pc + 4, "in link register");
    check_word(mem_at(32'h700), fill_word(10'h1c0), "word after JAL");
    check_word(mem_at(32'h704), fill_word(10'h1c1), "second word after JAL");
  endtask

  task automatic x0_test();
    start_program();
    emit(addi(5'd0, 5'd0, 12'h055));
    emit(NOP_W);
    emit(sw(5'd0, 5'd0, 12'h780));
    emit(EBREAK_W);
    run_program();
    check_word(mem_at(32'h780), '0, "x0 after ADDI");
  endtask

  initial begin
    seed    = 32'h7dfa;
    arst_n  = 1'b0;
    n_instr = 0;
    alu_test();
    for (int r = 0; r < 8; r++) begin
      random_test();
    end
    round_trip_test();
    branch_test();
    jal_test();
    x0_test();
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule
